//--- rtl/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DC_WAYS 4
`define DC_SETS 16
`define DC_LINE_WORDS 4

// everything at or above this address bypasses the cache
`define DC_DEVICE_BASE 32'h9000_0000

// beats in one refill burst, one per word of the line
`define DC_BURST_LEN 4

`endif

//--- rtl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	// byte address and data word on both the CPU and the memory side
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// request channel, held by the cache until memory takes it
	typedef struct packed {
		addr_t addr;
		// single-beat write
		logic  write;
		// four-beat line read, lowest word first
		logic  burst;
		word_t wdata;
	} mem_req_t;

	// one response beat
	typedef struct packed {
		word_t rdata;
		// final beat of a burst, or the only beat of a single access
		logic  last;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/cache_types_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package cache_types_pkg;

	localparam int INDEX_W  = $clog2(`DC_SETS);
	localparam int OFFSET_W = $clog2(`DC_LINE_WORDS);
	// byte-in-word bits are the two below the word offset
	localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [`DC_WAYS-1:0] way_vec_t;

	// address fields, same bit order as addr[31:2]
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} lookup_t;

	// one refill beat headed for the victim way
	typedef struct packed {
		index_t             index;
		offset_t            offset;
		mem_bus_pkg::word_t data;
		logic               last;
	} fill_t;

	typedef enum logic [2:0] {
		IDLE,
		MEM_REQ,
		REFILL,
		SINGLE,
		RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/dcache_way.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_way (
	input  logic                     clk,
	input  logic                     rst,
	input  cache_types_pkg::lookup_t lookup,
	input  cache_types_pkg::fill_t   fill,
	input  logic                     fill_sel,
	input  logic                     inval,
	output logic                     hit,
	output mem_bus_pkg::word_t       rd_word
);
	import cache_types_pkg::*;
	import mem_bus_pkg::*;

	tag_t                tags [`DC_SETS];
	logic [`DC_SETS-1:0] valid_bits;
	word_t               data [`DC_SETS][`DC_LINE_WORDS];

	logic                tag_match;
	logic                set_valid;

	// compare against the set selected by the current address
	assign tag_match = tags[lookup.index] == lookup.tag;
	assign set_valid = valid_bits[lookup.index];

	// valid bits and the registered hit
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			hit        <= 1'b0;
		end else begin
			hit <= set_valid && tag_match;
			if (fill_sel) begin
				// line is not usable until its last word has landed
				valid_bits[fill.index] <= fill.last;
			end else if (inval && hit) begin
				// write-through store hit this way, drop the stale copy
				valid_bits[lookup.index] <= 1'b0;
			end
		end
	end

	// tag and data arrays
	always_ff @(posedge clk) begin
		if (fill_sel) begin
			data[fill.index][fill.offset] <= fill.data;
			// tag comes from the miss address, still held by the CPU
			if (fill.last) begin
				tags[fill.index] <= lookup.tag;
			end
		end
		rd_word <= data[lookup.index][lookup.offset];
	end

	// refill and store never overlap, the controller is in REFILL or IDLE
	assert property (@(posedge clk) disable iff (rst)
		!(fill_sel && inval));

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      valid,
	input  mem_bus_pkg::addr_t        addr,
	input  logic                      wren,
	input  mem_bus_pkg::word_t        din,
	output logic                      ready,
	input  cache_types_pkg::way_vec_t way_hit,
	output cache_types_pkg::lookup_t  lookup,
	output cache_types_pkg::fill_t    fill,
	output cache_types_pkg::way_vec_t fill_way,
	output logic                      fill_valid,
	output logic                      inval,
	output logic                      resp_load,
	output logic                      bypass_valid,
	output mem_bus_pkg::word_t        bypass_word,
	output logic                      count_hit,
	output logic                      count_miss,
	output mem_bus_pkg::mem_req_t     mem_req,
	output logic                      mem_req_valid,
	input  logic                      mem_req_ready,
	input  mem_bus_pkg::mem_rsp_t     mem_rsp,
	input  logic                      mem_rsp_valid
);
	import cache_types_pkg::*;
	import mem_bus_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	way_vec_t    victim;
	offset_t     beat_cnt;
	addr_t       line_addr;
	logic        cacheable;
	logic        burst;
	logic        lookup_ok;
	logic        refilled;
	logic        take;
	logic        read_hit;

	// word-address bits map straight onto tag/index/offset
	assign lookup    = lookup_t'(addr[31:2]);
	assign cacheable = addr < `DC_DEVICE_BASE;
	assign burst     = cacheable && !wren;
	assign line_addr = {lookup.tag, lookup.index, {(OFFSET_W + 2){1'b0}}};

	// way hits are registered, so only trust them once the address
	// has been stable across one edge in IDLE or RESPOND
	assign take     = state == IDLE && valid && lookup_ok;
	assign read_hit = take && burst && |way_hit;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (read_hit) begin
					state_next = RESPOND;
				end else if (take) begin
					state_next = MEM_REQ;
				end
			end
			MEM_REQ: begin
				if (mem_req_ready) begin
					state_next = burst ? REFILL : SINGLE;
				end
			end
			REFILL: begin
				// back to IDLE, the re-lookup then hits
				if (mem_rsp_valid && mem_rsp.last) begin
					state_next = IDLE;
				end
			end
			SINGLE: begin
				if (mem_rsp_valid) begin
					state_next = RESPOND;
				end
			end
			RESPOND: begin
				// covers the ready cycle plus one more
				if (!ready) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			ready     <= 1'b0;
			victim    <= way_vec_t'(1);
			beat_cnt  <= '0;
			lookup_ok <= 1'b0;
			refilled  <= 1'b0;
		end else begin
			state     <= state_next;
			ready     <= resp_load;
			lookup_ok <= valid && (state == IDLE || state == RESPOND);
			// victim rotates freely while idle, frozen during a miss
			if (state == IDLE) begin
				victim <= {victim[`DC_WAYS-2:0], victim[`DC_WAYS-1]};
			end
			if (state == MEM_REQ) begin
				beat_cnt <= '0;
			end else if (fill_valid) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			if (fill_valid && mem_rsp.last) begin
				refilled <= 1'b1;
			end else if (resp_load) begin
				refilled <= 1'b0;
			end
		end
	end

	// memory request, held steady by the CPU-side address and data
	assign mem_req_valid = state == MEM_REQ;
	assign mem_req.addr  = burst ? line_addr : addr;
	assign mem_req.write = wren;
	assign mem_req.burst = burst;
	assign mem_req.wdata = din;

	// refill beats
	assign fill.index  = lookup.index;
	assign fill.offset = beat_cnt;
	assign fill.data   = mem_rsp.rdata;
	assign fill.last   = mem_rsp.last;
	assign fill_way    = victim;
	assign fill_valid  = state == REFILL && mem_rsp_valid;

	// store invalidates the matching line on acceptance
	assign inval = take && wren;

	// response side
	assign resp_load    = read_hit || (state == SINGLE && mem_rsp_valid);
	assign bypass_valid = state == SINGLE;
	assign bypass_word  = mem_rsp.rdata;
	assign count_hit    = read_hit && !refilled;
	assign count_miss   = state == MEM_REQ && mem_req_ready && burst;

	assert property (@(posedge clk) disable iff (rst)
		ready |=> !ready);

	// memory marks the end of a burst on exactly the last word
	assert property (@(posedge clk) disable iff (rst)
		fill_valid && mem_rsp.last |-> beat_cnt == offset_t'(`DC_BURST_LEN - 1));

endmodule

`default_nettype wire

//--- rtl/dcache_resp.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_resp (
	input  logic                              clk,
	input  logic                              rst,
	input  cache_types_pkg::way_vec_t         way_hit,
	input  mem_bus_pkg::word_t [`DC_WAYS-1:0] rd_word,
	input  logic                              resp_load,
	input  logic                              bypass_valid,
	input  mem_bus_pkg::word_t                bypass_word,
	input  logic                              count_hit,
	input  logic                              count_miss,
	output mem_bus_pkg::word_t                dout,
	output logic [31:0]                       hit_count,
	output logic [31:0]                       miss_count
);
	import cache_types_pkg::*;
	import mem_bus_pkg::*;

	way_vec_t hit_q;
	logic     bypass_q;
	word_t    bypass_word_q;
	word_t    way_word;

	// response source, captured the cycle before ready
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q    <= '0;
			bypass_q <= 1'b0;
		end else if (resp_load) begin
			hit_q    <= way_hit;
			bypass_q <= bypass_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_load) begin
			bypass_word_q <= bypass_word;
		end
	end

	// AND-OR merge of the way words, hit_q is one-hot on a hit
	always_comb begin
		way_word = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			way_word = way_word | (rd_word[w] & {$bits(word_t){hit_q[w]}});
		end
	end

	assign dout = bypass_q ? bypass_word_q : way_word;

	// statistics
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_count  <= '0;
			miss_count <= '0;
		end else begin
			if (count_hit) begin
				hit_count <= hit_count + 1'b1;
			end
			if (count_miss) begin
				miss_count <= miss_count + 1'b1;
			end
		end
	end

	// a cached response comes from exactly one way
	assert property (@(posedge clk) disable iff (rst)
		resp_load && !bypass_valid |=> $onehot(hit_q));

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
	input  logic                  clk,
	input  logic                  rst,
	// CPU load/store port
	input  logic                  valid,
	input  mem_bus_pkg::addr_t    addr,
	input  logic                  wren,
	input  mem_bus_pkg::word_t    din,
	output logic                  ready,
	output mem_bus_pkg::word_t    dout,
	output logic [31:0]           hit_count,
	output logic [31:0]           miss_count,
	// memory bus
	output mem_bus_pkg::mem_req_t mem_req,
	output logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	input  mem_bus_pkg::mem_rsp_t mem_rsp,
	input  logic                  mem_rsp_valid
);
	import cache_types_pkg::*;
	import mem_bus_pkg::*;

	lookup_t                lookup;
	fill_t                  fill;
	way_vec_t               fill_way;
	logic                   fill_valid;
	logic                   inval;
	way_vec_t               way_hit;
	word_t [`DC_WAYS-1:0]   rd_word;
	logic                   resp_load;
	logic                   bypass_valid;
	word_t                  bypass_word;
	logic                   count_hit;
	logic                   count_miss;

	dcache_ctrl ctrl0 (
		.clk           (clk),
		.rst           (rst),
		.valid         (valid),
		.addr          (addr),
		.wren          (wren),
		.din           (din),
		.ready         (ready),
		.way_hit       (way_hit),
		.lookup        (lookup),
		.fill          (fill),
		.fill_way      (fill_way),
		.fill_valid    (fill_valid),
		.inval         (inval),
		.resp_load     (resp_load),
		.bypass_valid  (bypass_valid),
		.bypass_word   (bypass_word),
		.count_hit     (count_hit),
		.count_miss    (count_miss),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid)
	);

	// all ways see the same lookup, only the victim takes refill beats
	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		dcache_way way0 (
			.clk      (clk),
			.rst      (rst),
			.lookup   (lookup),
			.fill     (fill),
			.fill_sel (fill_valid && fill_way[w]),
			.inval    (inval),
			.hit      (way_hit[w]),
			.rd_word  (rd_word[w])
		);
	end

	dcache_resp resp0 (
		.clk          (clk),
		.rst          (rst),
		.way_hit      (way_hit),
		.rd_word      (rd_word),
		.resp_load    (resp_load),
		.bypass_valid (bypass_valid),
		.bypass_word  (bypass_word),
		.count_hit    (count_hit),
		.count_miss   (count_miss),
		.dout         (dout),
		.hit_count    (hit_count),
		.miss_count   (miss_count)
	);

endmodule

`default_nettype wire

//--- test/burst_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module burst_mem #(
	parameter int REQ_DELAY = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  mem_bus_pkg::mem_req_t mem_req,
	input  logic                  mem_req_valid,
	output logic                  mem_req_ready,
	output mem_bus_pkg::mem_rsp_t mem_rsp,
	output logic                  mem_rsp_valid
);
	import mem_bus_pkg::*;

	// only written words live here, the rest reads the fill pattern
	word_t store [addr_t];
	int    delay_cnt;
	int    beats_left;
	addr_t beat_addr;
	logic  reply_write;

	// odd multiplier, so every address bit changes the word
	function automatic word_t fill_pattern(addr_t a);
		return (a * 32'h9e37_79b1) ^ 32'h3c5a_0f69;
	endfunction

	function automatic word_t read_word(addr_t a);
		if (store.exists(a)) begin
			return store[a];
		end
		return fill_pattern(a);
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			mem_req_ready <= 1'b0;
			mem_rsp_valid <= 1'b0;
			mem_rsp       <= '0;
			delay_cnt     <= 0;
			beats_left    <= 0;
			reply_write   <= 1'b0;
		end else begin
			mem_rsp_valid <= 1'b0;
			if (mem_req_valid && mem_req_ready) begin
				// request taken on this edge
				mem_req_ready <= 1'b0;
				beat_addr     <= mem_req.addr;
				beats_left    <= mem_req.burst ? `DC_BURST_LEN : 1;
				reply_write   <= mem_req.write;
				if (mem_req.write) begin
					store[mem_req.addr] = mem_req.wdata;
				end
			end else if (beats_left > 0) begin
				// one beat per cycle, lowest word first
				mem_rsp_valid <= 1'b1;
				mem_rsp.rdata <= reply_write ? '0 : read_word(beat_addr);
				mem_rsp.last  <= beats_left == 1;
				beat_addr     <= beat_addr + 32'd4;
				beats_left    <= beats_left - 1;
			end else if (mem_req_valid) begin
				if (delay_cnt == REQ_DELAY) begin
					mem_req_ready <= 1'b1;
					delay_cnt     <= 0;
				end else begin
					delay_cnt <= delay_cnt + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- test/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;
	import mem_bus_pkg::*;

	localparam int    CLK_PERIOD = 100;
	// valid seen at the next edge, ready one edge after that
	localparam int    HIT_CYCLES = 2;
	localparam int    REPL_READS = 40;
	localparam int    RANDOM_OPS = 200;
	localparam int    NUM_REQS   = 2 + 3 + 5 + REPL_READS + 3 + 3 + RANDOM_OPS;
	localparam addr_t LINE_A     = 32'h0000_1230;

	logic        clk;
	logic        rst;
	logic        valid;
	addr_t       addr;
	logic        wren;
	word_t       din;
	logic        ready;
	word_t       dout;
	logic [31:0] hit_count;
	logic [31:0] miss_count;
	mem_req_t    mem_req;
	logic        mem_req_valid;
	logic        mem_req_ready;
	mem_rsp_t    mem_rsp;
	logic        mem_rsp_valid;

	word_t       shadow [addr_t];
	logic [31:0] rng_state;
	logic [31:0] hits_snap;
	logic [31:0] misses_snap;
	string       test_name;
	int          errors;
	int          test_errors;
	int          tests_run;
	logic        exp_read;
	word_t       exp_dout;

	dcache_top dut0 (
		.clk           (clk),
		.rst           (rst),
		.valid         (valid),
		.addr          (addr),
		.wren          (wren),
		.din           (din),
		.ready         (ready),
		.dout          (dout),
		.hit_count     (hit_count),
		.miss_count    (miss_count),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid)
	);

	burst_mem mem0 (
		.clk           (clk),
		.rst           (rst),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// initial memory contents
	function automatic word_t mem_word(addr_t a);
		return (a * 32'h9e37_79b1) ^ 32'h3c5a_0f69;
	endfunction

	function automatic word_t expected_word(addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return mem_word(a);
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
		$display("** Error: %s: expected %h, actual %h", what, expected, actual);
		errors++;
		test_errors++;
	endtask

	// read data check at every ready
	always @(negedge clk) begin
		if (!rst && ready && exp_read) begin
			if (dout !== exp_dout) begin
				report_mismatch({test_name, " read data"}, exp_dout, dout);
			end
		end
	end

	task automatic access(input addr_t a, input logic w, input word_t d, output int cycles);
		int counted;
		int events;
		logic [31:0] hits0;
		logic [31:0] misses0;
		@(negedge clk);
		exp_read = !w;
		exp_dout = expected_word(a);
		hits0    = hit_count;
		misses0  = miss_count;
		valid    = 1'b1;
		addr     = a;
		wren     = w;
		din      = d;
		cycles   = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ready);
		valid = 1'b0;
		wren  = 1'b0;
		if (w) begin
			shadow[a] = d;
		end
		// a cacheable read counts exactly once, anything else not at all
		counted = (!w && a < `DC_DEVICE_BASE) ? 1 : 0;
		events  = (hit_count - hits0) + (miss_count - misses0);
		if (events != counted) begin
			report_mismatch({test_name, " event count"}, counted, events);
		end
	endtask

	task automatic snapshot();
		hits_snap   = hit_count;
		misses_snap = miss_count;
	endtask

	task automatic check_counts(string what, int dh, int dm);
		if (hit_count - hits_snap != dh) begin
			report_mismatch({what, " hit_count"}, hits_snap + dh, hit_count);
		end
		if (miss_count - misses_snap != dm) begin
			report_mismatch({what, " miss_count"}, misses_snap + dm, miss_count);
		end
	endtask

	task automatic start_test(string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		// let the compare process see the last ready first
		@(posedge clk);
		tests_run++;
		if (test_errors == 0) begin
			$display("%-18s ok", test_name);
		end else begin
			$display("%-18s FAILED, %0d errors", test_name, test_errors);
		end
	endtask

	task automatic cold_read();
		int cycles;
		start_test("cold_read");
		snapshot();
		access(LINE_A, 1'b0, '0, cycles);
		check_counts("cold_read first read", 0, 1);
		snapshot();
		access(LINE_A, 1'b0, '0, cycles);
		check_counts("cold_read re-read", 1, 0);
		if (cycles != HIT_CYCLES) begin
			report_mismatch("cold_read hit latency", HIT_CYCLES, cycles);
		end
		close_test();
	endtask

	task automatic line_fill();
		int cycles;
		start_test("line_fill");
		for (int off = 1; off < `DC_LINE_WORDS; off++) begin
			snapshot();
			access(LINE_A + 32'(off * 4), 1'b0, '0, cycles);
			check_counts("line_fill", 1, 0);
		end
		close_test();
	endtask

	task automatic replacement();
		int cycles;
		logic [31:0] r;
		start_test("replacement");
		// five tags competing for set 5
		for (int i = 0; i < 5; i++) begin
			access(32'h0001_0050 + 32'(i) * 32'h100, 1'b0, '0, cycles);
		end
		for (int n = 0; n < REPL_READS; n++) begin
			r = next_rand();
			access(32'h0001_0050 + (r % 5) * 32'h100 + ((r >> 8) % 4) * 4, 1'b0, '0, cycles);
		end
		close_test();
	endtask

	task automatic write_invalidate();
		int cycles;
		start_test("write_invalidate");
		snapshot();
		access(LINE_A, 1'b0, '0, cycles);
		check_counts("write_invalidate cached read", 1, 0);
		snapshot();
		access(LINE_A, 1'b1, 32'hcafe_f00d, cycles);
		check_counts("write_invalidate write", 0, 0);
		snapshot();
		access(LINE_A, 1'b0, '0, cycles);
		check_counts("write_invalidate read back", 0, 1);
		close_test();
	endtask

	task automatic uncached_access();
		int cycles;
		start_test("uncached_access");
		snapshot();
		access(`DC_DEVICE_BASE, 1'b0, '0, cycles);
		access(`DC_DEVICE_BASE + 32'h40, 1'b1, 32'h1234_5678, cycles);
		access(`DC_DEVICE_BASE + 32'h40, 1'b0, '0, cycles);
		check_counts("uncached_access", 0, 0);
		close_test();
	endtask

	task automatic random_mix();
		int cycles;
		logic [31:0] r;
		start_test("random_mix");
		// 128 words, two tags per set
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r = next_rand();
			access(32'h0000_2000 + {r[6:0], 2'b00}, r[9:8] == 2'b00, next_rand(), cycles);
		end
		close_test();
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		valid       = 1'b0;
		addr        = '0;
		wren        = 1'b0;
		din         = '0;
		rng_state   = 32'd90213;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		exp_read    = 1'b0;
		exp_dout    = '0;
		test_name   = "reset";
		repeat (4) @(negedge clk);
		rst = 1'b0;
		if (hit_count !== '0 || miss_count !== '0) begin
			$display("counters are not zero after reset");
			errors++;
		end
		cold_read();
		line_fill();
		replacement();
		write_invalidate();
		uncached_access();
		random_mix();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// 40 cycles per request is far above the slowest miss
	initial begin
		#((NUM_REQS * 40 + 4) * CLK_PERIOD);
		$display("watchdog expired, the DUT stopped answering requests");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/cache_types_pkg.sv
rtl/dcache_way.sv
rtl/dcache_ctrl.sv
rtl/dcache_resp.sv
rtl/dcache_top.sv
test/burst_mem.sv
test/dcache_tb.sv
